// ==== source/tcdm_pkg.sv ====
package tcdm_pkg;

   // **************************************************************************
   // Bus widths shared by masters, crossbar and banks
   // **************************************************************************

   localparam int unsigned DATA_WIDTH  = 32;            // One data word
   localparam int unsigned ADDR_WIDTH  = 32;            // Byte address from a master
   localparam int unsigned BE_WIDTH    = DATA_WIDTH/8;  // One enable per byte lane

   // Byte offset inside a word, skipped when picking the bank
   localparam int unsigned WORD_OFFSET = 2;

   // **************************************************************************
   // Data types
   // **************************************************************************

   typedef logic [DATA_WIDTH-1:0] data_t;
   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [BE_WIDTH-1:0]   be_t;

   // Request opcode, same sense as the wen line of the bus
   // A set bit is a read, a clear bit is a write
   typedef enum logic
   {
      TCDM_WRITE = 1'b0,
      TCDM_READ  = 1'b1
   } tcdm_op_e;

endpackage

// ==== source/tcdm_bank_if.sv ====
`timescale 1ns/10ps

// One bank port of the crossbar
// The bank always accepts, so there is no grant line
interface tcdm_bank_if
#(
   parameter int unsigned NB_MASTERS      = 4,
   parameter int unsigned BANK_ADDR_WIDTH = 8
)
();

   localparam int unsigned ID_WIDTH = (NB_MASTERS > 1) ? $clog2(NB_MASTERS) : 1;

   // Request side
   logic                       req;
   logic [BANK_ADDR_WIDTH-1:0] add;      // Row inside the bank
   tcdm_pkg::tcdm_op_e         op;
   tcdm_pkg::data_t            wdata;
   tcdm_pkg::be_t              be;
   logic [ID_WIDTH-1:0]        id;       // Index of the winning master

   // Response side, one cycle after req
   logic                       r_valid;
   tcdm_pkg::data_t            r_rdata;
   logic [ID_WIDTH-1:0]        r_id;

   modport xbar
   (
      output req, add, op, wdata, be, id,
      input  r_valid, r_rdata, r_id
   );

   modport bank
   (
      input  req, add, op, wdata, be, id,
      output r_valid, r_rdata, r_id
   );

endinterface

// ==== source/tcdm_rr_arbiter.sv ====
`timescale 1ns/10ps

// Round-robin arbiter for one bank
// Grant is combinational, the pointer moves at the next clock edge
module tcdm_rr_arbiter
#(
   parameter int unsigned NB_MASTERS = 4
)
(
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  logic [NB_MASTERS-1:0] req_i,
   output logic [NB_MASTERS-1:0] gnt_o,
   output logic [((NB_MASTERS > 1) ? $clog2(NB_MASTERS) : 1)-1:0] sel_o
);

   localparam int unsigned IDX_WIDTH = (NB_MASTERS > 1) ? $clog2(NB_MASTERS) : 1;

   logic [IDX_WIDTH-1:0] ptr_q;    // Master with highest priority
   logic [IDX_WIDTH-1:0] ptr_d;
   logic                 any_req;

   assign any_req = |req_i;

   // **************************************************************************
   // Winner selection
   // **************************************************************************

   // Scan from the pointer upwards and wrap, first requester wins
   always_comb
   begin
      int   idx;
      logic found;

      gnt_o = '0;
      sel_o = '0;
      found = 1'b0;
      for (int i = 0; i < int'(NB_MASTERS); i++)
      begin
         idx = (int'(ptr_q) + i) % int'(NB_MASTERS);
         if (!found && req_i[idx])
         begin
            found      = 1'b1;
            gnt_o[idx] = 1'b1;
            sel_o      = IDX_WIDTH'(idx);
         end
      end
   end

   // **************************************************************************
   // Priority pointer
   // **************************************************************************

   // Master after the winner gets top priority next
   always_comb
   begin
      if (sel_o == IDX_WIDTH'(NB_MASTERS-1))
         ptr_d = '0;
      else
         ptr_d = sel_o + 1'b1;
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         ptr_q <= '0;             // Master 0 first after reset
      end
      else if (any_req)
      begin
         ptr_q <= ptr_d;
      end
   end

endmodule

// ==== source/tcdm_bank_sram.sv ====
`timescale 1ns/10ps

// Single-port memory bank with byte-enable writes
// Every request is answered one cycle later, reads and writes alike
module tcdm_bank_sram
#(
   parameter int unsigned NB_MASTERS      = 4,
   parameter int unsigned BANK_ADDR_WIDTH = 8
)
(
   input logic       clk_i,
   input logic       rst_ni,
   tcdm_bank_if.bank bank_io
);

   localparam int unsigned ID_WIDTH = (NB_MASTERS > 1) ? $clog2(NB_MASTERS) : 1;
   localparam int unsigned NB_WORDS = 2**BANK_ADDR_WIDTH;

   tcdm_pkg::data_t     mem_q [NB_WORDS];
   tcdm_pkg::data_t     rdata_q;
   logic                r_valid_q;
   logic [ID_WIDTH-1:0] r_id_q;

   // **************************************************************************
   // Storage array and read port
   // **************************************************************************

   always_ff @(posedge clk_i)
   begin
      if (bank_io.req)
      begin
         if (bank_io.op == tcdm_pkg::TCDM_WRITE)
         begin
            for (int b = 0; b < int'(tcdm_pkg::BE_WIDTH); b++)
            begin
               if (bank_io.be[b])
                  mem_q[bank_io.add][b*8 +: 8] <= bank_io.wdata[b*8 +: 8];
            end
         end
         rdata_q <= mem_q[bank_io.add];   // Old word on a write, ignored by master
      end
   end

   // **************************************************************************
   // Response control
   // **************************************************************************

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         r_valid_q <= 1'b0;
         r_id_q    <= '0;
      end
      else
      begin
         r_valid_q <= bank_io.req;
         if (bank_io.req)
            r_id_q <= bank_io.id;          // Remember who gets the answer
      end
   end

   assign bank_io.r_valid = r_valid_q;
   assign bank_io.r_rdata = rdata_q;
   assign bank_io.r_id    = r_id_q;

endmodule

// ==== source/tcdm_xbar.sv ====
`timescale 1ns/10ps

// Logarithmic crossbar between masters and word-interleaved banks
module tcdm_xbar
#(
   parameter int unsigned NB_MASTERS      = 4,
   parameter int unsigned NB_BANKS        = 8,
   parameter int unsigned BANK_ADDR_WIDTH = 8
)
(
   input  logic                                   clk_i,
   input  logic                                   rst_ni,

   // Master side
   input  logic               [NB_MASTERS-1:0]    data_req_i,
   input  tcdm_pkg::addr_t    [NB_MASTERS-1:0]    data_add_i,
   input  tcdm_pkg::tcdm_op_e [NB_MASTERS-1:0]    data_op_i,
   input  tcdm_pkg::data_t    [NB_MASTERS-1:0]    data_wdata_i,
   input  tcdm_pkg::be_t      [NB_MASTERS-1:0]    data_be_i,
   output logic               [NB_MASTERS-1:0]    data_gnt_o,
   output logic               [NB_MASTERS-1:0]    data_r_valid_o,
   output tcdm_pkg::data_t    [NB_MASTERS-1:0]    data_r_rdata_o,

   // Bank side
   tcdm_bank_if.xbar                              bank_io [NB_BANKS]
);

   localparam int unsigned ID_WIDTH   = (NB_MASTERS > 1) ? $clog2(NB_MASTERS) : 1;
   localparam int unsigned BANK_SEL_W = (NB_BANKS > 1) ? $clog2(NB_BANKS) : 1;
   localparam int unsigned ROW_LSB    = tcdm_pkg::WORD_OFFSET + $clog2(NB_BANKS);

   logic [NB_MASTERS-1:0][BANK_SEL_W-1:0]      bank_sel;   // Target bank per master
   logic [NB_MASTERS-1:0][BANK_ADDR_WIDTH-1:0] row;        // Row inside that bank

   logic [NB_BANKS-1:0][NB_MASTERS-1:0]        bank_req;
   logic [NB_BANKS-1:0][NB_MASTERS-1:0]        bank_gnt;
   logic [NB_BANKS-1:0][ID_WIDTH-1:0]          bank_win;

   logic            [NB_BANKS-1:0]             r_valid_bank;
   logic            [NB_BANKS-1:0][ID_WIDTH-1:0] r_id_bank;
   tcdm_pkg::data_t [NB_BANKS-1:0]             r_rdata_bank;

   // **************************************************************************
   // Address decode, word interleaved
   // **************************************************************************

   always_comb
   begin
      for (int m = 0; m < int'(NB_MASTERS); m++)
      begin
         bank_sel[m] = data_add_i[m][tcdm_pkg::WORD_OFFSET +: BANK_SEL_W];
         row[m]      = data_add_i[m][ROW_LSB +: BANK_ADDR_WIDTH];   // Upper bits ignored
      end
   end

   // **************************************************************************
   // Per-bank arbitration and request mux
   // **************************************************************************

   for (genvar b = 0; b < NB_BANKS; b++)
   begin : g_bank
      always_comb
      begin
         for (int m = 0; m < int'(NB_MASTERS); m++)
            bank_req[b][m] = data_req_i[m] && (bank_sel[m] == BANK_SEL_W'(b));
      end

      tcdm_rr_arbiter
      #(
         .NB_MASTERS ( NB_MASTERS )
      )
      i_arb
      (
         .clk_i  ( clk_i        ),
         .rst_ni ( rst_ni       ),
         .req_i  ( bank_req[b]  ),
         .gnt_o  ( bank_gnt[b]  ),
         .sel_o  ( bank_win[b]  )
      );

      assign bank_io[b].req   = |bank_req[b];
      assign bank_io[b].add   = row[bank_win[b]];
      assign bank_io[b].op    = data_op_i[bank_win[b]];
      assign bank_io[b].wdata = data_wdata_i[bank_win[b]];
      assign bank_io[b].be    = data_be_i[bank_win[b]];
      assign bank_io[b].id    = bank_win[b];

      assign r_valid_bank[b]  = bank_io[b].r_valid;
      assign r_id_bank[b]     = bank_io[b].r_id;
      assign r_rdata_bank[b]  = bank_io[b].r_rdata;
   end

   // **************************************************************************
   // Grant return and response routing
   // **************************************************************************

   // A master targets one bank, so at most one grant and one answer per master
   always_comb
   begin
      data_gnt_o     = '0;
      data_r_valid_o = '0;
      data_r_rdata_o = '0;
      for (int m = 0; m < int'(NB_MASTERS); m++)
      begin
         for (int b = 0; b < int'(NB_BANKS); b++)
         begin
            data_gnt_o[m] = data_gnt_o[m] | bank_gnt[b][m];
            if (r_valid_bank[b] && (r_id_bank[b] == ID_WIDTH'(m)))
            begin
               data_r_valid_o[m] = 1'b1;
               data_r_rdata_o[m] = r_rdata_bank[b];
            end
         end
      end
   end

endmodule

// ==== source/tcdm_cluster_top.sv ====
`timescale 1ns/10ps

// Cluster TCDM, crossbar plus bank array
module tcdm_cluster_top
#(
   parameter int unsigned NB_MASTERS      = 4,
   parameter int unsigned NB_BANKS        = 8,
   parameter int unsigned BANK_ADDR_WIDTH = 8
)
(
   input  logic                                clk_i,
   input  logic                                rst_ni,

   input  logic               [NB_MASTERS-1:0] data_req_i,
   input  tcdm_pkg::addr_t    [NB_MASTERS-1:0] data_add_i,
   input  tcdm_pkg::tcdm_op_e [NB_MASTERS-1:0] data_op_i,
   input  tcdm_pkg::data_t    [NB_MASTERS-1:0] data_wdata_i,
   input  tcdm_pkg::be_t      [NB_MASTERS-1:0] data_be_i,
   output logic               [NB_MASTERS-1:0] data_gnt_o,
   output logic               [NB_MASTERS-1:0] data_r_valid_o,
   output tcdm_pkg::data_t    [NB_MASTERS-1:0] data_r_rdata_o
);

   // One bus per bank between crossbar and memory
   tcdm_bank_if
   #(
      .NB_MASTERS      ( NB_MASTERS      ),
      .BANK_ADDR_WIDTH ( BANK_ADDR_WIDTH )
   )
   bank_bus [NB_BANKS] ();

   // **************************************************************************
   // Crossbar
   // **************************************************************************

   tcdm_xbar
   #(
      .NB_MASTERS      ( NB_MASTERS      ),
      .NB_BANKS        ( NB_BANKS        ),
      .BANK_ADDR_WIDTH ( BANK_ADDR_WIDTH )
   )
   i_xbar
   (
      .clk_i          ( clk_i          ),
      .rst_ni         ( rst_ni         ),
      .data_req_i     ( data_req_i     ),
      .data_add_i     ( data_add_i     ),
      .data_op_i      ( data_op_i      ),
      .data_wdata_i   ( data_wdata_i   ),
      .data_be_i      ( data_be_i      ),
      .data_gnt_o     ( data_gnt_o     ),
      .data_r_valid_o ( data_r_valid_o ),
      .data_r_rdata_o ( data_r_rdata_o ),
      .bank_io        ( bank_bus       )
   );

   // **************************************************************************
   // Memory banks
   // **************************************************************************

   for (genvar b = 0; b < NB_BANKS; b++)
   begin : g_sram
      tcdm_bank_sram
      #(
         .NB_MASTERS      ( NB_MASTERS      ),
         .BANK_ADDR_WIDTH ( BANK_ADDR_WIDTH )
      )
      i_bank
      (
         .clk_i   ( clk_i       ),
         .rst_ni  ( rst_ni      ),
         .bank_io ( bank_bus[b] )
      );
   end

endmodule

// ==== bench/tcdm_tb_chk.sv ====
`timescale 1ns/10ps

// Handshake properties on the master ports of the cluster TCDM
module tcdm_tb_chk
#(
   parameter int unsigned NB_MASTERS = 4
)
(
   input logic                  clk_i,
   input logic                  rst_ni,
   input logic [NB_MASTERS-1:0] req_i,
   input logic [NB_MASTERS-1:0] gnt_i,
   input logic [NB_MASTERS-1:0] r_valid_i
);

   // No answer leaves a bank while reset is held
   a_no_valid_in_reset: assert property (@(posedge clk_i) !rst_ni |-> (r_valid_i == '0))
      else $error("Response valid during reset");

   for (genvar m = 0; m < NB_MASTERS; m++)
   begin : g_master
      a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
         gnt_i[m] |-> req_i[m])
         else $error("Grant without request on master %0d", m);

      // Accepted request is answered in the very next cycle
      a_valid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
         (req_i[m] && gnt_i[m]) |=> r_valid_i[m])
         else $error("Missing response on master %0d", m);

      a_valid_only_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
         r_valid_i[m] |-> $past(req_i[m] && gnt_i[m]))
         else $error("Response without grant on master %0d", m);
   end

endmodule

bind tcdm_cluster_top tcdm_tb_chk
#(
   .NB_MASTERS ( NB_MASTERS )
)
i_chk
(
   .clk_i     ( clk_i          ),
   .rst_ni    ( rst_ni         ),
   .req_i     ( data_req_i     ),
   .gnt_i     ( data_gnt_o     ),
   .r_valid_i ( data_r_valid_o )
);

// ==== bench/tcdm_tb.sv ====
`timescale 1ns/10ps

module tcdm_tb;

   localparam int unsigned NB_M           = 4;
   localparam int unsigned BANK_BITS      = 3;      // 8 banks
   localparam int unsigned ROW_BITS       = 8;
   localparam int unsigned ROW_LSB        = tcdm_pkg::WORD_OFFSET + BANK_BITS;
   localparam int unsigned RANDOM_CYCLES  = 800;
   localparam int unsigned TIMEOUT_CYCLES = 2000;   // All tests take about 900 cycles

   logic                          clk_i;
   logic                          rst_ni;
   logic               [NB_M-1:0] data_req_i;
   tcdm_pkg::addr_t    [NB_M-1:0] data_add_i;
   tcdm_pkg::tcdm_op_e [NB_M-1:0] data_op_i;
   tcdm_pkg::data_t    [NB_M-1:0] data_wdata_i;
   tcdm_pkg::be_t      [NB_M-1:0] data_be_i;
   logic               [NB_M-1:0] data_gnt_o;
   logic               [NB_M-1:0] data_r_valid_o;
   tcdm_pkg::data_t    [NB_M-1:0] data_r_rdata_o;

   // Request per master, held until granted
   logic               [NB_M-1:0] pend;
   tcdm_pkg::addr_t    [NB_M-1:0] p_add;
   tcdm_pkg::tcdm_op_e [NB_M-1:0] p_op;
   tcdm_pkg::data_t    [NB_M-1:0] p_wdata;
   tcdm_pkg::be_t      [NB_M-1:0] p_be;
   logic               [NB_M-1:0] exp_valid;      // Response due in the next cycle
   logic               [NB_M-1:0] exp_chk;
   tcdm_pkg::data_t    [NB_M-1:0] exp_data;
   logic               [NB_M-1:0] last_gnt;

   tcdm_pkg::data_t ref_mem [int unsigned];       // Key is {row, bank}
   logic [15:0]     lfsr_q;
   int unsigned     check_cnt;
   int unsigned     mismatch_cnt;
   int unsigned     failure_cnt;
   int unsigned     cycle_cnt = 0;

   tcdm_cluster_top UUT
   (
      .clk_i          ( clk_i          ),
      .rst_ni         ( rst_ni         ),
      .data_req_i     ( data_req_i     ),
      .data_add_i     ( data_add_i     ),
      .data_op_i      ( data_op_i      ),
      .data_wdata_i   ( data_wdata_i   ),
      .data_be_i      ( data_be_i      ),
      .data_gnt_o     ( data_gnt_o     ),
      .data_r_valid_o ( data_r_valid_o ),
      .data_r_rdata_o ( data_r_rdata_o )
   );

   always #50 clk_i = ~clk_i;

   always @(posedge clk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // *************************************************************************
   // Helpers
   // *************************************************************************

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
   function automatic logic [31:0] rand_bits(input int unsigned n);
      logic [31:0] val;
      logic        out;
      val = '0;
      for (int unsigned i = 0; i < n; i++)
      begin
         out    = lfsr_q[0];
         lfsr_q = lfsr_q >> 1;
         if (out)
            lfsr_q = lfsr_q ^ 16'hB400;
         val = {val[30:0], out};
      end
      return val;
   endfunction

   // Bank sits just above the byte offset, row above the bank bits
   function automatic tcdm_pkg::addr_t make_addr(input logic [2:0] bank, input logic [7:0] row,
                                                 input logic [3:0] top);
      return {top, 15'd0, row, bank, 2'b00};
   endfunction

   function automatic int unsigned mem_key(input tcdm_pkg::addr_t a);
      return {21'd0, a[ROW_LSB +: ROW_BITS], a[tcdm_pkg::WORD_OFFSET +: BANK_BITS]};
   endfunction

   task automatic compare_data(input string name, input tcdm_pkg::data_t got,
                               input tcdm_pkg::data_t exp);
      check_cnt++;
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_gnt(input logic [NB_M-1:0] got, input logic [NB_M-1:0] exp);
      check_cnt++;
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t: data_gnt_o got %b expected %b", $time, got, exp);
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      check_cnt++;
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic post_request(input int m, input tcdm_pkg::tcdm_op_e op,
                               input tcdm_pkg::addr_t addr, input tcdm_pkg::data_t wdata,
                               input tcdm_pkg::be_t be);
      pend[m]    = 1'b1;
      p_op[m]    = op;
      p_add[m]   = addr;
      p_wdata[m] = wdata;
      p_be[m]    = be;
   endtask

   // One clock: drive requests, check due responses, then score grants
   task automatic step_cycle();
      int unsigned     key;
      tcdm_pkg::data_t word;
      @(posedge clk_i);
      data_req_i   <= pend;
      data_add_i   <= p_add;
      data_op_i    <= p_op;
      data_wdata_i <= p_wdata;
      data_be_i    <= p_be;
      @(negedge clk_i);
      last_gnt = data_gnt_o;
      for (int m = 0; m < NB_M; m++)
      begin
         compare_flag($sformatf("data_r_valid_o[%0d]", m), data_r_valid_o[m], exp_valid[m]);
         if (exp_valid[m] && exp_chk[m])
            compare_data($sformatf("data_r_rdata_o[%0d]", m), data_r_rdata_o[m], exp_data[m]);
         exp_valid[m] = pend[m] & last_gnt[m];
         exp_chk[m]   = 1'b0;
         if (exp_valid[m])
         begin
            key = mem_key(p_add[m]);
            if (p_op[m] == tcdm_pkg::TCDM_READ)
            begin
               exp_chk[m] = (ref_mem.exists(key) != 0);
               if (exp_chk[m])
                  exp_data[m] = ref_mem[key];
            end
            else
            begin
               word = (ref_mem.exists(key) != 0) ? ref_mem[key] : 'x;
               for (int b = 0; b < 4; b++)
                  if (p_be[m][b])
                     word[b*8 +: 8] = p_wdata[m][b*8 +: 8];   // Merge enabled bytes
               ref_mem[key] = word;
            end
            pend[m] = 1'b0;
         end
      end
   endtask

   // With k masters on one bank the last grant comes within k cycles
   task automatic run_pending();
      int unsigned waited;
      waited = 0;
      while (|pend)
      begin
         step_cycle();
         waited++;
         if (waited >= NB_M && |pend)
         begin
            failure_cnt++;
            $display("Requests %b were not granted within %0d cycles", pend, waited);
            pend = '0;
         end
      end
   endtask

   task automatic wait_all_done();
      run_pending();
      step_cycle();                                // Collect the last responses
   endtask

   task automatic apply_reset();
      @(posedge clk_i);
      rst_ni     <= 1'b0;
      data_req_i <= '0;
      pend      = '0;
      exp_valid = '0;
      repeat (2)
      begin
         @(negedge clk_i);
         for (int m = 0; m < NB_M; m++)
            compare_flag($sformatf("data_r_valid_o[%0d]", m), data_r_valid_o[m], 1'b0);
         compare_gnt(data_gnt_o, '0);
      end
      @(posedge clk_i);
      rst_ni <= 1'b1;
   endtask

   // *************************************************************************
   // Directed tests
   // *************************************************************************

   task automatic test_reset();
      apply_reset();
      repeat (2)
      begin
         step_cycle();
         compare_gnt(last_gnt, '0);
      end
   endtask

   // Full words first, partial overwrite by odd masters, then cross reads
   task automatic test_write_read();
      int unsigned     bank;
      tcdm_pkg::data_t wdata;
      for (int ph = 0; ph < 3; ph++)
      begin
         for (int b = 0; b < 8; b++)
         begin
            for (int m = 0; m < NB_M; m++)
            begin
               bank  = (b + m) % 8;
               wdata = 32'hA5C3_0000 ^ 32'((m << 12) | (bank << 4) | ph);
               if (ph == 0)
                  post_request(m, tcdm_pkg::TCDM_WRITE, make_addr(3'(bank), 8'(m), 4'h0),
                               wdata, 4'hF);
               else if (ph == 1 && (m % 2) == 1)
                  post_request(m, tcdm_pkg::TCDM_WRITE, make_addr(3'(bank), 8'(m), 4'h0),
                               ~wdata, 4'b0110);
               else if (ph == 2)
                  post_request(m, tcdm_pkg::TCDM_READ,
                               make_addr(3'(bank), 8'((m + 1) % NB_M), 4'h0), '0, '0);
            end
            run_pending();
         end
      end
      step_cycle();
   endtask

   task automatic test_parallel();
      for (int m = 0; m < NB_M; m++)
         post_request(m, tcdm_pkg::TCDM_READ, make_addr(3'(2 * m), 8'(NB_M - 1 - m), 4'hF),
                      '0, '0);
      step_cycle();
      compare_gnt(last_gnt, '1);
      step_cycle();                                // All answers due here
   endtask

   // Writes in the first round, reads of the same word in the second
   task automatic test_conflict();
      apply_reset();
      for (int m = 0; m < NB_M; m++)
         post_request(m, tcdm_pkg::TCDM_WRITE, make_addr(3'd0, 8'd0, 4'h0),
                      32'h1000_0001 * (m + 1), 4'hF);
      for (int k = 0; k < 2 * NB_M; k++)
      begin
         step_cycle();
         compare_gnt(last_gnt, NB_M'(1 << (k % NB_M)));
         // Winner asks again at once, so only the pointer keeps it waiting
         if (k < NB_M)
            post_request(k, tcdm_pkg::TCDM_READ, make_addr(3'd0, 8'd0, 4'h0), '0, '0);
      end
      step_cycle();
   endtask

   // Rows 0 to 3 of every bank are known, so every read can be checked
   task automatic test_random();
      logic op_bit;
      for (int c = 0; c < RANDOM_CYCLES; c++)
      begin
         for (int m = 0; m < NB_M; m++)
         begin
            if (!pend[m] && rand_bits(1) == 32'd1)
            begin
               op_bit = 1'(rand_bits(1));
               post_request(m, tcdm_pkg::tcdm_op_e'(op_bit),
                            make_addr(3'(rand_bits(3)), 8'(rand_bits(2)), 4'(rand_bits(4))),
                            rand_bits(32), 4'(rand_bits(4)));
            end
         end
         step_cycle();
      end
      wait_all_done();
   endtask

   initial
   begin
      clk_i        = 1'b0;
      rst_ni       = 1'b0;
      lfsr_q       = 16'd29;
      check_cnt    = 0;
      mismatch_cnt = 0;
      failure_cnt  = 0;
      pend         = '0;
      p_add        = '0;
      p_wdata      = '0;
      p_be         = '0;
      exp_valid    = '0;
      exp_chk      = '0;
      exp_data     = '0;
      last_gnt     = '0;
      for (int m = 0; m < NB_M; m++)
         p_op[m] = tcdm_pkg::TCDM_READ;
      data_req_i   = '0;
      data_add_i   = '0;
      data_op_i    = p_op;
      data_wdata_i = '0;
      data_be_i    = '0;

      test_reset();
      test_write_read();
      test_parallel();
      test_conflict();
      test_random();

      $display("Done: %0d checks, %0d mismatches, %0d other failures",
               check_cnt, mismatch_cnt, failure_cnt);
      if (mismatch_cnt == 0 && failure_cnt == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== list.f ====
source/tcdm_pkg.sv
source/tcdm_bank_if.sv
source/tcdm_rr_arbiter.sv
source/tcdm_bank_sram.sv
source/tcdm_xbar.sv
source/tcdm_cluster_top.sv
bench/tcdm_tb_chk.sv
bench/tcdm_tb.sv

// ==== Makefile ====
# Verilator build and run of the cluster TCDM testbench

VERILATOR ?= verilator
TOP       ?= tcdm_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_TEXT ?= ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
